// ==== source/copper_pkg.sv ====
// Shared types and constants for the display coprocessor
package copper_pkg;

    // Program counter, beam coordinate and data word widths
    localparam int PC_W   = 11;
    localparam int POS_W  = 11;
    localparam int WORD_W = 16;

    // Opcode lives in the top nibble of the first instruction word
    typedef enum logic [3:0] {
        OP_WAIT  = 4'b0000,
        OP_SKIP  = 4'b0010,
        OP_JMP   = 4'b0100,
        OP_MOVER = 4'b1001,
        OP_MOVEF = 4'b1010,
        OP_MOVEP = 4'b1011,
        OP_MOVEC = 4'b1100
    } opcode_t;

    // Fetch sequencer states
    typedef enum logic [2:0] {
        ST_INIT   = 3'b000,
        ST_WAIT   = 3'b001,
        ST_LATCH1 = 3'b010,
        ST_LATCH2 = 3'b011,
        ST_EXEC   = 3'b100
    } fetch_state_t;

    // First word: opcode plus Y position, jump target or move address
    typedef struct packed {
        opcode_t     opcode;
        logic [11:0] operand;
    } insn_hi_t;

    // Second word as seen by WAIT and SKIP
    // flags[0] ignores Y, flags[1] ignores X
    typedef struct packed {
        logic             unused;
        logic [POS_W-1:0] x;
        logic [3:0]       flags;
    } pos_word_t;

    // Second word is either a position or the move payload
    typedef union packed {
        pos_word_t         pos;
        logic [WORD_W-1:0] data;
    } insn_lo_u;

    typedef struct packed {
        insn_hi_t hi;
        insn_lo_u lo;
    } insn_t;

    // Outgoing XR write
    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;
    } xr_wr_t;

    // Host load port of the program memory
    typedef struct packed {
        logic              en;
        logic [PC_W-1:0]   addr;
        logic [WORD_W-1:0] data;
    } host_wr_t;

    // How the PC moves after an instruction
    typedef enum logic [1:0] {
        PC_NEXT    = 2'b00,
        PC_SKIP3   = 2'b01,
        PC_JUMP    = 2'b10,
        PC_RESTART = 2'b11
    } pc_op_t;

    typedef struct packed {
        logic            done;
        pc_op_t          op;
        logic [PC_W-1:0] target;
    } exec_result_t;

    // XR address regions reached by the MOVE variants
    localparam logic [15:0] XR_REG_BASE = 16'h0000;
    localparam logic [15:0] TILE_BASE   = 16'h4000;
    localparam logic [15:0] COLOR_BASE  = 16'h8000;
    localparam logic [15:0] COPPER_BASE = 16'hC000;

    // XR register number of the copper control register
    localparam logic [3:0] COPP_CTRL_REG = 4'd1;

endpackage

// ==== source/copper_frame_ctrl.sv ====
`timescale 1ns/1ps

module copper_frame_ctrl #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                              clk,
    input  logic                              copp_reset,
    input  logic                              ctrl_wr_i,
    input  logic [3:0]                        ctrl_num_i,
    input  logic [copper_pkg::WORD_W-1:0]     ctrl_data_i,
    input  logic [copper_pkg::POS_W-1:0]      h_count_i,
    input  logic [copper_pkg::POS_W-1:0]      v_count_i,
    output logic                              enable_o,
    output logic [copper_pkg::PC_W-1:0]       init_pc_o,
    output logic                              frame_restart_o
);

    // Position of the restart pulse, a few pixels before the frame wraps
    localparam logic [copper_pkg::POS_W-1:0] RESTART_H = copper_pkg::POS_W'(H_TOTAL - 5);
    localparam logic [copper_pkg::POS_W-1:0] RESTART_V = copper_pkg::POS_W'(V_TOTAL - 1);

    logic                        enable_q;
    logic [copper_pkg::PC_W-1:0] init_pc_q;

    // Control register
    // Bit 15 enables, bits 10:0 give the initial PC, bits 14:11 are dropped
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            enable_q  <= 1'b0;
            init_pc_q <= '0;
        end else if (ctrl_wr_i && ctrl_num_i == copper_pkg::COPP_CTRL_REG) begin
            enable_q  <= ctrl_data_i[15];
            init_pc_q <= ctrl_data_i[copper_pkg::PC_W-1:0];
        end
    end

    assign enable_o  = enable_q;
    assign init_pc_o = init_pc_q;

    // One cycle pulse on the last line, so the first fetch is done before the new frame
    assign frame_restart_o = (h_count_i == RESTART_H) && (v_count_i == RESTART_V);

endmodule

// ==== source/copper_prog_mem.sv ====
`timescale 1ns/1ps

module copper_prog_mem (
    input  logic                          clk,
    input  copper_pkg::host_wr_t          host_wr_i,
    input  logic                          rd_en_i,
    input  logic [copper_pkg::PC_W-1:0]   rd_addr_i,
    output logic [copper_pkg::WORD_W-1:0] rd_data_o
);

    localparam int DEPTH = 2 ** copper_pkg::PC_W;

    // 2K words of copper program
    logic [copper_pkg::WORD_W-1:0] mem [DEPTH];
    logic [copper_pkg::WORD_W-1:0] rd_data_q;

    // Host load port
    always_ff @(posedge clk) begin
        if (host_wr_i.en) begin
            mem[host_wr_i.addr] <= host_wr_i.data;
        end
    end

    // Fetch port, one cycle latency
    // Same address write in the same cycle still returns the old word
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_q <= mem[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

// ==== source/copper_fetch.sv ====
`timescale 1ns/1ps

module copper_fetch (
    input  logic                          clk,
    input  logic                          copp_reset,
    input  logic                          enable_i,
    input  logic [copper_pkg::PC_W-1:0]   init_pc_i,
    input  logic                          frame_restart_i,
    input  logic [copper_pkg::WORD_W-1:0] rd_data_i,
    input  copper_pkg::exec_result_t      result_i,
    output logic                          rd_en_o,
    output logic [copper_pkg::PC_W-1:0]   rd_addr_o,
    output copper_pkg::insn_t             insn_o,
    output logic                          exec_valid_o
);

    copper_pkg::fetch_state_t    state_q;
    logic [copper_pkg::PC_W-1:0] pc_q;
    logic                        rd_en_q;
    copper_pkg::insn_t           insn_q;

    // PC and sequencer
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state_q <= copper_pkg::ST_INIT;
            pc_q    <= '0;
            rd_en_q <= 1'b0;
        end else if (frame_restart_i) begin
            // New frame starts over at the programmed PC
            state_q <= copper_pkg::ST_INIT;
            pc_q    <= init_pc_i;
            rd_en_q <= 1'b0;
        end else if (enable_i) begin
            case (state_q)
                // Only used at frame start or after an illegal opcode
                copper_pkg::ST_INIT: begin
                    rd_en_q <= 1'b1;
                    state_q <= copper_pkg::ST_WAIT;
                end
                // RAM reads the first word, PC moves on to the second
                copper_pkg::ST_WAIT: begin
                    pc_q    <= pc_q + 1'b1;
                    state_q <= copper_pkg::ST_LATCH1;
                end
                copper_pkg::ST_LATCH1: begin
                    state_q <= copper_pkg::ST_LATCH2;
                end
                copper_pkg::ST_LATCH2: begin
                    rd_en_q <= 1'b0;
                    state_q <= copper_pkg::ST_EXEC;
                end
                // Stay here until the executor reports done
                copper_pkg::ST_EXEC: begin
                    if (result_i.done) begin
                        rd_en_q <= 1'b1;
                        state_q <= copper_pkg::ST_WAIT;
                        case (result_i.op)
                            copper_pkg::PC_NEXT:  pc_q <= pc_q + 1'b1;
                            copper_pkg::PC_SKIP3: pc_q <= pc_q + 2'd3;
                            copper_pkg::PC_JUMP:  pc_q <= result_i.target;
                            default: begin
                                // Illegal opcode, step past it and refetch from INIT
                                pc_q    <= pc_q + 1'b1;
                                rd_en_q <= 1'b0;
                                state_q <= copper_pkg::ST_INIT;
                            end
                        endcase
                    end
                end
                default: begin
                    state_q <= copper_pkg::ST_INIT;
                end
            endcase
        end
    end

    // Instruction words, read data is valid one cycle after the address
    always_ff @(posedge clk) begin
        if (enable_i && state_q == copper_pkg::ST_LATCH1) begin
            insn_q.hi <= rd_data_i;
        end
        if (enable_i && state_q == copper_pkg::ST_LATCH2) begin
            insn_q.lo <= rd_data_i;
        end
    end

    assign rd_en_o   = rd_en_q;
    assign rd_addr_o = pc_q;
    assign insn_o    = insn_q;

    // No execution in a restart cycle, the PC is being reloaded
    assign exec_valid_o = enable_i && !frame_restart_i && state_q == copper_pkg::ST_EXEC;

endmodule

// ==== source/copper_exec.sv ====
`timescale 1ns/1ps

module copper_exec (
    input  logic                         clk,
    input  logic                         copp_reset,
    input  logic                         exec_valid_i,
    input  copper_pkg::insn_t            insn_i,
    input  logic [copper_pkg::POS_W-1:0] h_count_i,
    input  logic [copper_pkg::POS_W-1:0] v_count_i,
    input  logic                         xr_ack_i,
    output copper_pkg::exec_result_t     result_o,
    output copper_pkg::xr_wr_t           xr_wr_o,
    output logic                         xr_req_o
);

    logic        ignore_x;
    logic        ignore_y;
    logic        pos_hit;
    logic        is_move;
    logic        start_wr;
    logic [15:0] wr_addr;

    // Handshake state
    logic               req_q;
    logic               hs_busy_q;
    copper_pkg::xr_wr_t xr_wr_q;

    // Position compare, lower word read as X plus flags
    assign ignore_y = insn_i.lo.pos.flags[0];
    assign ignore_x = insn_i.lo.pos.flags[1];
    assign pos_hit  = (ignore_x || h_count_i >= insn_i.lo.pos.x) &&
                      (ignore_y || v_count_i >= insn_i.hi.operand[copper_pkg::POS_W-1:0]);

    // Decode
    always_comb begin
        result_o.done   = 1'b1;
        result_o.op     = copper_pkg::PC_NEXT;
        result_o.target = insn_i.hi.operand[copper_pkg::PC_W-1:0];
        is_move         = 1'b0;
        wr_addr         = copper_pkg::XR_REG_BASE;
        case (insn_i.hi.opcode)
            copper_pkg::OP_WAIT: begin
                // Both coordinates ignored waits out the frame
                result_o.done = pos_hit && !(ignore_x && ignore_y);
            end
            copper_pkg::OP_SKIP: begin
                // Jump over the next two-word instruction
                if (pos_hit) begin
                    result_o.op = copper_pkg::PC_SKIP3;
                end
            end
            copper_pkg::OP_JMP: begin
                result_o.op = copper_pkg::PC_JUMP;
            end
            copper_pkg::OP_MOVER: begin
                is_move = 1'b1;
                wr_addr = copper_pkg::XR_REG_BASE | {8'h00, insn_i.hi.operand[7:0]};
            end
            copper_pkg::OP_MOVEF: begin
                is_move = 1'b1;
                wr_addr = copper_pkg::TILE_BASE | {4'h0, insn_i.hi.operand[11:0]};
            end
            copper_pkg::OP_MOVEP: begin
                is_move = 1'b1;
                wr_addr = copper_pkg::COLOR_BASE | {8'h00, insn_i.hi.operand[7:0]};
            end
            copper_pkg::OP_MOVEC: begin
                is_move = 1'b1;
                wr_addr = copper_pkg::COPPER_BASE | {5'h00, insn_i.hi.operand[10:0]};
            end
            default: begin
                result_o.op = copper_pkg::PC_RESTART;
            end
        endcase
        // A MOVE stalls while the previous write is still in its handshake
        if (is_move) begin
            result_o.done = !hs_busy_q;
        end
    end

    assign start_wr = exec_valid_i && is_move && !hs_busy_q;

    // Four-phase req/ack
    // busy stays set from req rising until ack has dropped again
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            req_q     <= 1'b0;
            hs_busy_q <= 1'b0;
        end else if (start_wr) begin
            req_q     <= 1'b1;
            hs_busy_q <= 1'b1;
        end else if (req_q && xr_ack_i) begin
            req_q <= 1'b0;
        end else if (hs_busy_q && !req_q && !xr_ack_i) begin
            hs_busy_q <= 1'b0;
        end
    end

    // Address and data held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (start_wr) begin
            xr_wr_q.addr <= wr_addr;
            xr_wr_q.data <= insn_i.lo.data;
        end
    end

    assign xr_req_o = req_q;
    assign xr_wr_o  = xr_wr_q;

endmodule

// ==== source/copper_top.sv ====
`timescale 1ns/1ps

module copper_top #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                          clk,
    input  logic                          copp_reset,
    input  logic                          ctrl_wr_i,
    input  logic [3:0]                    ctrl_num_i,
    input  logic [copper_pkg::WORD_W-1:0] ctrl_data_i,
    input  copper_pkg::host_wr_t          host_wr_i,
    input  logic [copper_pkg::POS_W-1:0]  h_count_i,
    input  logic [copper_pkg::POS_W-1:0]  v_count_i,
    input  logic                          xr_ack_i,
    output copper_pkg::xr_wr_t            xr_wr_o,
    output logic                          xr_req_o
);

    // Control to fetch
    logic                          enable;
    logic [copper_pkg::PC_W-1:0]   init_pc;
    logic                          frame_restart;

    // Fetch to program memory
    logic                          rd_en;
    logic [copper_pkg::PC_W-1:0]   rd_addr;
    logic [copper_pkg::WORD_W-1:0] rd_data;

    // Fetch and exec
    copper_pkg::insn_t             insn;
    logic                          exec_valid;
    copper_pkg::exec_result_t      result;

    copper_frame_ctrl #(
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL)
    ) copper_frame_ctrl_i (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .ctrl_wr_i       (ctrl_wr_i),
        .ctrl_num_i      (ctrl_num_i),
        .ctrl_data_i     (ctrl_data_i),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .enable_o        (enable),
        .init_pc_o       (init_pc),
        .frame_restart_o (frame_restart)
    );

    copper_prog_mem copper_prog_mem_i (
        .clk       (clk),
        .host_wr_i (host_wr_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    copper_fetch copper_fetch_i (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .enable_i        (enable),
        .init_pc_i       (init_pc),
        .frame_restart_i (frame_restart),
        .rd_data_i       (rd_data),
        .result_i        (result),
        .rd_en_o         (rd_en),
        .rd_addr_o       (rd_addr),
        .insn_o          (insn),
        .exec_valid_o    (exec_valid)
    );

    copper_exec copper_exec_i (
        .clk          (clk),
        .copp_reset   (copp_reset),
        .exec_valid_i (exec_valid),
        .insn_i       (insn),
        .h_count_i    (h_count_i),
        .v_count_i    (v_count_i),
        .xr_ack_i     (xr_ack_i),
        .result_o     (result),
        .xr_wr_o      (xr_wr_o),
        .xr_req_o     (xr_req_o)
    );

endmodule

// ==== bench/copper_properties.sv ====
`timescale 1ns/1ps

module copper_properties (
    input logic               clk,
    input logic               copp_reset,
    input logic               xr_req_o,
    input logic               xr_ack_i,
    input copper_pkg::xr_wr_t xr_wr_o
);

    // Request holds with a stable word until the sink answers
    req_held: assert property (@(posedge clk) disable iff (copp_reset)
        xr_req_o && !xr_ack_i |=> xr_req_o && $stable(xr_wr_o))
        else $error("xr_req_o dropped or xr_wr_o changed before ack");

    // Reset clears the request
    req_reset: assert property (@(posedge clk) copp_reset |=> !xr_req_o)
        else $error("xr_req_o high after reset");

    // No new request until ack has fallen
    req_after_ack: assert property (@(posedge clk) disable iff (copp_reset)
        $rose(xr_req_o) |-> !xr_ack_i)
        else $error("xr_req_o rose while xr_ack_i still high");

endmodule

bind copper_exec copper_properties copper_properties_i (.*);

// ==== bench/copper_tb.sv ====
`timescale 1ns/1ps

module copper_tb;

    localparam int H_TOT = 64;
    localparam int V_TOT = 16;

    logic                 clk;
    logic                 copp_reset;
    logic                 ctrl_wr;
    logic [3:0]           ctrl_num;
    logic [15:0]          ctrl_data;
    copper_pkg::host_wr_t host_wr;
    logic [10:0]          h_count;
    logic [10:0]          v_count;
    logic                 xr_ack;
    copper_pkg::xr_wr_t   xr_wr;
    logic                 xr_req;

    // Program image, also walked by the reference model
    logic [15:0] prog [128];

    // Expected writes of the current frame, with the earliest raster position
    logic [15:0] exp_addr_q [$];
    logic [15:0] exp_data_q [$];
    int          exp_min_q [$];

    int   err_count;
    int   write_count;
    bit   timed_out;
    logic req_seen;
    int   ack_phase;
    int   ack_delay;
    int   pos;
    int   e_min;
    logic [15:0] e_addr;
    logic [15:0] e_data;

    copper_top #(
        .H_TOTAL(H_TOT),
        .V_TOTAL(V_TOT)
    ) copper_top_i (
        .clk         (clk),
        .copp_reset  (copp_reset),
        .ctrl_wr_i   (ctrl_wr),
        .ctrl_num_i  (ctrl_num),
        .ctrl_data_i (ctrl_data),
        .host_wr_i   (host_wr),
        .h_count_i   (h_count),
        .v_count_i   (v_count),
        .xr_ack_i    (xr_ack),
        .xr_wr_o     (xr_wr),
        .xr_req_o    (xr_req)
    );

    always #2 clk = ~clk;

    // Raster counters, as the video timing would run them
    always @(negedge clk) begin
        if (copp_reset) begin
            h_count = '0;
            v_count = '0;
        end else if (h_count == H_TOT - 1) begin
            h_count = '0;
            v_count = (v_count == V_TOT - 1) ? '0 : v_count + 1'b1;
        end else begin
            h_count = h_count + 1'b1;
        end
    end

    // Sink side of the four-phase handshake with random delays
    always @(negedge clk) begin
        if (copp_reset) begin
            xr_ack    = 1'b0;
            ack_phase = 0;
        end else if (ack_phase == 0 && xr_req) begin
            ack_delay = $urandom % 12;
            ack_phase = 1;
        end else if (ack_phase == 1) begin
            if (ack_delay == 0) begin
                xr_ack    = 1'b1;
                ack_phase = 2;
            end else begin
                ack_delay--;
            end
        end else if (ack_phase == 2 && !xr_req) begin
            ack_delay = $urandom % 12;
            ack_phase = 3;
        end else if (ack_phase == 3) begin
            if (ack_delay == 0) begin
                xr_ack    = 1'b0;
                ack_phase = 0;
            end else begin
                ack_delay--;
            end
        end
    end

    // Walks the program from start_pc and queues the writes of one frame
    function automatic void expected_writes(int start_pc);
        int          pc;
        int          min_lin;
        int          cand;
        bit          hit;
        logic [3:0]  op;
        logic [11:0] opd;
        logic [10:0] x;
        logic [3:0]  fl;
        pc      = start_pc;
        min_lin = 0;
        for (int n = 0; n < 64; n++) begin
            op  = prog[pc][15:12];
            opd = prog[pc][11:0];
            x   = prog[pc+1][14:4];
            fl  = prog[pc+1][3:0];
            case (op)
                4'b0000: begin
                    // Both ignored never completes
                    if (fl[0] && fl[1]) break;
                    if (fl[0])
                        cand = (min_lin / H_TOT) * H_TOT + (fl[1] ? 0 : int'(x));
                    else
                        cand = int'(opd) * H_TOT + (fl[1] ? 0 : int'(x));
                    if (cand > min_lin) min_lin = cand;
                    pc += 2;
                end
                4'b0010: begin
                    hit = (fl[1] || (min_lin % H_TOT) >= int'(x)) &&
                          (fl[0] || (min_lin / H_TOT) >= int'(opd));
                    pc += hit ? 4 : 2;
                end
                4'b0100: pc = int'(opd[10:0]);
                4'b1001, 4'b1010, 4'b1011, 4'b1100: begin
                    case (op)
                        4'b1001: exp_addr_q.push_back({8'h00, opd[7:0]});
                        4'b1010: exp_addr_q.push_back({4'h4, opd});
                        4'b1011: exp_addr_q.push_back({8'h80, opd[7:0]});
                        default: exp_addr_q.push_back({5'b11000, opd[10:0]});
                    endcase
                    exp_data_q.push_back(prog[pc+1]);
                    exp_min_q.push_back(min_lin);
                    pc += 2;
                end
                // Illegal opcodes fall through to the next instruction
                default: pc += 2;
            endcase
        end
    endfunction

    // Compares each new request with the next expected write
    always @(posedge clk) begin
        #1;
        if (!copp_reset && xr_req && !req_seen) begin
            write_count++;
            pos = int'(v_count) * H_TOT + int'(h_count);
            if (exp_addr_q.size() == 0) begin
                err_count++;
                $display("Unexpected XR write at %0t to address %h", $time, xr_wr.addr);
            end else begin
                e_addr = exp_addr_q.pop_front();
                e_data = exp_data_q.pop_front();
                e_min  = exp_min_q.pop_front();
                if (xr_wr.addr !== e_addr) begin
                    err_count++;
                    $display("ERR %0t xr_wr_o.addr expected %h got %h", $time, e_addr, xr_wr.addr);
                end
                if (xr_wr.data !== e_data) begin
                    err_count++;
                    $display("ERR %0t xr_wr_o.data expected %h got %h", $time, e_data, xr_wr.data);
                end
                if (pos < e_min) begin
                    err_count++;
                    $display("ERR %0t beam_position expected >= %0d got %0d", $time, e_min, pos);
                end
            end
        end
        req_seen = copp_reset ? 1'b0 : xr_req;
    end

    // Waits for a raster position, one frame and a bit at most
    task automatic wait_pos(int h, int v);
        int n;
        n = 0;
        @(posedge clk);
        while (!(h_count == h && v_count == v) && n < 3000) begin
            @(posedge clk);
            n++;
        end
        if (n >= 3000) begin
            timed_out = 1'b1;
            $display("Timeout at %0t waiting for raster position h=%0d v=%0d", $time, h, v);
        end
    endtask

    task automatic write_ctrl(logic [15:0] data);
        @(negedge clk);
        ctrl_wr   = 1'b1;
        ctrl_num  = 4'd1;
        ctrl_data = data;
        @(negedge clk);
        ctrl_wr   = 1'b0;
    endtask

    // Every frame must have produced all of its writes before the restart
    task automatic check_frame_done();
        if (exp_addr_q.size() != 0) begin
            err_count++;
            $display("Frame ended at %0t with %0d writes missing", $time, exp_addr_q.size());
            exp_addr_q.delete();
            exp_data_q.delete();
            exp_min_q.delete();
        end
    endtask

    task automatic put_insn(int addr, logic [3:0] op, int opd, logic [15:0] lo);
        prog[addr]   = {op, 12'(opd)};
        prog[addr+1] = lo;
    endtask

    function automatic logic [15:0] pos_lo(int x, logic [3:0] fl);
        return {1'b0, 11'(x), fl};
    endfunction

    task automatic build_program();
        for (int a = 0; a < 128; a++) begin
            prog[a] = 16'h0000;
        end
        // Program A at 0
        put_insn(0, 4'b1001, 12'h012, 16'h1111);
        put_insn(2, 4'b1010, 12'hABC, 16'h2222);
        put_insn(4, 4'b0000, 2, pos_lo(20, 4'b0000));
        put_insn(6, 4'b1011, 12'h034, 16'h3333);
        put_insn(8, 4'b0000, 0, pos_lo(40, 4'b0001));
        put_insn(10, 4'b1001, 12'h056, 16'h4444);
        put_insn(12, 4'b0000, 5, pos_lo(0, 4'b0010));
        put_insn(14, 4'b1100, 12'h7FF, 16'h5555);
        put_insn(16, 4'b0010, 0, pos_lo(0, 4'b0011));
        put_insn(18, 4'b1001, 12'h001, 16'hDEAD);
        put_insn(20, 4'b0010, 0, pos_lo(0, 4'b0000));
        put_insn(22, 4'b1001, 12'h002, 16'hBEEF);
        put_insn(24, 4'b0010, 15, pos_lo(62, 4'b0000));
        put_insn(26, 4'b1011, 12'h005, 16'h6666);
        put_insn(28, 4'b1111, 0, 16'h0000);
        put_insn(30, 4'b1010, 12'h001, 16'h7777);
        put_insn(32, 4'b0100, 40, 16'h0000);
        put_insn(34, 4'b1001, 12'h003, 16'hBAD0);
        put_insn(40, 4'b1001, 12'h004, 16'h8888);
        put_insn(42, 4'b0000, 0, pos_lo(0, 4'b0011));
        // Program B at 64
        put_insn(64, 4'b1011, 12'h07F, 16'h9999);
        put_insn(66, 4'b0000, 3, pos_lo(8, 4'b0000));
        put_insn(68, 4'b1100, 12'h010, 16'hAAAA);
        put_insn(70, 4'b0000, 0, pos_lo(0, 4'b0011));
    endtask

    task automatic load_program();
        for (int a = 0; a < 128; a++) begin
            @(negedge clk);
            host_wr.en   = 1'b1;
            host_wr.addr = 11'(a);
            host_wr.data = prog[a];
        end
        @(negedge clk);
        host_wr.en = 1'b0;
    endtask

    task automatic run_scenario();
        wait_pos(0, 0);
        if (timed_out) return;
        expected_writes(0);
        write_ctrl(16'h8000);
        // Frame 0 ends, program A again in frame 1
        wait_pos(59, 15);
        if (timed_out) return;
        check_frame_done();
        expected_writes(0);
        // New init_pc takes effect from frame 2
        wait_pos(0, 10);
        if (timed_out) return;
        write_ctrl(16'h8000 | 16'd64);
        wait_pos(59, 15);
        if (timed_out) return;
        check_frame_done();
        expected_writes(64);
        // Disabled copper stays silent in frame 3
        wait_pos(0, 10);
        if (timed_out) return;
        write_ctrl(16'h0000);
        wait_pos(59, 15);
        if (timed_out) return;
        check_frame_done();
        wait_pos(59, 15);
    endtask

    initial begin
        void'($urandom(95957));
        clk         = 1'b0;
        copp_reset <= 1'b1;
        ctrl_wr     = 1'b0;
        ctrl_num    = '0;
        ctrl_data   = '0;
        host_wr     = '0;
        h_count     = '0;
        v_count     = '0;
        xr_ack      = 1'b0;
        err_count   = 0;
        write_count = 0;
        timed_out   = 1'b0;
        req_seen    = 1'b0;
        ack_phase   = 0;
        build_program();
        repeat (3) @(negedge clk);
        // Raster and sink still see reset in this falling edge
        copp_reset <= 1'b0;
        load_program();
        run_scenario();
        $display("Writes seen %0d, errors %0d", write_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/copper_pkg.sv
source/copper_frame_ctrl.sv
source/copper_prog_mem.sv
source/copper_fetch.sv
source/copper_exec.sv
source/copper_top.sv
bench/copper_properties.sv
bench/copper_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the copper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module copper_tb \
    -Mdir obj_dir -o copper_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/copper_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
